//--- compile.f
+incdir+tb
design/eg_pkg.sv
design/eg_slot_if.sv
design/eg_slot_regs.sv
design/eg_timer.sv
design/eg_state_mem.sv
design/eg_calc_env.sv
design/eg_top.sv
tb/eg_tb.sv

//--- Makefile
# Verilator build and run of the envelope generator testbench.

VERILATOR ?= verilator
TOP ?= eg_tb
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/eg_model.svh
// Reference model of the envelope generator.
// Keeps its own sequencer, settings and per-slot envelope memory.
`ifndef EG_MODEL_SVH
`define EG_MODEL_SVH

op_word_t m_op [num_slots];
ch_word_t m_ch [num_slots];
int m_env [num_slots];
eg_state_t m_state [num_slots];
bit m_key [num_slots];
bit [3:0] seen_st [num_slots]; // states each slot has entered.
bit seen_pr [num_slots];
int m_slot;
int m_count;
int exp_slot;
int exp_level;
eg_state_t exp_state;
bit exp_pr;

task automatic model_reset();
	int s;
	for (s = 0; s < num_slots; s++) begin
		m_op[s] = '0;
		m_ch[s] = '0;
		m_env[s] = 127;
		m_state[s] = EG_DAMP;
		m_key[s] = 1'b0;
	end
	m_slot = 0;
	m_count = 0;
endtask

task automatic clear_seen();
	int s;
	for (s = 0; s < num_slots; s++) begin
		seen_st[s] = '0;
		seen_pr[s] = 1'b0;
	end
endtask

function automatic int key_scaled_rate(input int basic, input op_word_t op, input ch_word_t ch);
	int bf;
	int r;
	bf = ch.block * 2 + ch.fnum[8];
	r = basic * 4 + (op.ksr ? bf : bf / 4);
	if (basic == 0)
		return 0;
	return (r > 63) ? 63 : r;
endfunction

// one visit of the current slot, the same work the DUT does in one cycle.
task automatic model_visit();
	op_word_t op;
	ch_word_t ch;
	eg_state_t st;
	int env;
	int basic;
	int rate;
	int hi;
	int sh;
	int low;
	int col;
	bit rel;
	bit atk;
	bit stp;
	op = m_op[m_slot];
	ch = m_ch[m_slot];
	env = m_env[m_slot];
	st = m_state[m_slot];
	exp_pr = 1'b0;
	if (ch.key_on && !m_key[m_slot]) begin
		st = EG_DAMP;
	end else if (st == EG_DAMP && env >= 124 && ch.key_on) begin
		st = EG_ATTACK;
		exp_pr = 1'b1;
	end else if (st == EG_ATTACK && env == 0) begin
		st = EG_DECAY;
	end else if (st == EG_DECAY && env / 8 == op.sl) begin
		st = EG_SUSTAIN;
	end
	rel = op.op_type && !ch.key_on; // a released carrier.
	atk = !rel && st == EG_ATTACK;
	case (st)
		EG_DAMP: basic = 12;
		EG_ATTACK: basic = op.ar;
		EG_DECAY: basic = op.dr;
		default: basic = op.egtyp ? 0 : op.rr;
	endcase
	if (rel)
		basic = op.egtyp ? op.rr : (ch.sust_on ? 5 : 7);
	rate = key_scaled_rate(basic, op, ch);
	hi = rate / 4;
	sh = (hi <= 12) ? 13 - hi : 0;
	low = m_count % (1 << sh);
	col = 0;
	if (hi == 0 || hi == 15)
		col = 0;
	else if (hi == 14 || (atk && hi >= 12))
		col = ((m_count >> 2) % 4) * 2;
	else if (hi == 13)
		col = ((m_count >> 2) % 4) * 2 + m_count % 2;
	else if (atk || low == 0)
		col = (m_count >> sh) % 8;
	stp = eg_step_bit(5'((rate % 4) * 8 + col));
	if (atk) begin
		if (hi == 15)
			env = 0;
		else if (hi >= 12)
			env = env - (env >> (stp ? 15 - hi : 16 - hi)) - 1;
		else if (hi != 0 && low < 4 && stp)
			env = env - env / 16 - 1;
	end else if (hi != 0) begin
		if (hi == 15)
			env = env + 2;
		else if (hi == 14)
			env = env + stp + 1;
		else if (hi == 13 || low == 0)
			env = env + stp;
		if (env > 127)
			env = 127;
	end
	m_env[m_slot] = env;
	m_state[m_slot] = st;
	m_key[m_slot] = ch.key_on;
	seen_st[m_slot][st] = 1'b1;
	if (exp_pr)
		seen_pr[m_slot] = 1'b1;
	exp_slot = m_slot;
	exp_level = env;
	exp_state = st;
	if (m_slot == num_slots - 1) begin
		m_slot = 0;
		m_count = (m_count + 1) % 65536;
	end else begin
		m_slot = m_slot + 1;
	end
endtask

`endif

//--- tb/eg_tb.sv
// Testbench for the envelope generator.
// Drives host writes into eg_top and checks every slot result against a model.
`timescale 1ns/100ps
`default_nettype none

module eg_tb;

	import eg_pkg::*;

	localparam int num_slots = 18;
	localparam int wait_limit = 400000; // cycles per phase.
	localparam int random_sweeps = 3000;

	logic clk;
	logic reset;
	logic op_wr;
	logic ch_wr;
	logic [4:0] wr_slot;
	op_word_t op_data;
	ch_word_t ch_data;
	logic env_valid;
	logic [4:0] env_slot;
	env_t env_level;
	eg_state_t env_state;
	logic phase_reset;

	integer seed;
	int error_count;
	bit pend_op;
	bit pend_ch;
	int pend_slot;

	`include "eg_model.svh"

	eg_top #(.num_slots(num_slots)) eg_top_inst (
		.clk(clk),
		.reset(reset),
		.op_wr(op_wr),
		.ch_wr(ch_wr),
		.wr_slot(wr_slot),
		.op_data(op_data),
		.ch_data(ch_data),
		.env_valid(env_valid),
		.env_slot(env_slot),
		.env_level(env_level),
		.env_state(env_state),
		.phase_reset(phase_reset)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			error_count++;
			$display("[FAIL] %s expected 0x%0h received 0x%0h", name, expected, got);
			$display("Finished with errors");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic op_word_t rand_op(input int lo, input int hi);
		op_word_t op;
		op.egtyp = 1'(rand_range(0, 1));
		op.ksr = 1'(rand_range(0, 1));
		op.ar = rate4_t'(rand_range(lo, hi));
		op.dr = rate4_t'(rand_range(lo, hi));
		op.sl = rate4_t'(rand_range(0, 15));
		op.rr = rate4_t'(rand_range(lo, hi));
		op.op_type = 1'(rand_range(0, 1));
		return op;
	endfunction

	function automatic ch_word_t rand_ch(input bit key_on);
		ch_word_t ch;
		ch.sust_on = 1'(rand_range(0, 1));
		ch.key_on = key_on;
		ch.fnum = fnum_t'(rand_range(0, 511));
		ch.block = block_t'(rand_range(0, 7));
		return ch;
	endfunction

	// Checks the result of the last visit and then lets the model make this cycle's visit.
	task automatic tick();
		@(posedge clk);
		#2;
		check_value("env_valid", env_valid, 1);
		check_value("env_slot", env_slot, exp_slot);
		check_value("env_level", env_level, exp_level);
		check_value("env_state", env_state, exp_state);
		check_value("phase_reset", phase_reset, exp_pr);
		if (pend_op)
			m_op[pend_slot] = op_data;
		if (pend_ch)
			m_ch[pend_slot] = ch_data;
		model_visit();
		op_wr = 1'b0;
		ch_wr = 1'b0;
		pend_op = 1'b0;
		pend_ch = 1'b0;
	endtask

	task automatic drive_op(input int s, input op_word_t w);
		op_wr = 1'b1;
		wr_slot = 5'(s);
		op_data = w;
		pend_op = 1'b1;
		pend_slot = s;
		tick();
	endtask

	task automatic drive_ch(input int s, input ch_word_t w);
		ch_wr = 1'b1;
		wr_slot = 5'(s);
		ch_data = w;
		pend_ch = 1'b1;
		pend_slot = s;
		tick();
	endtask

	function automatic bit phase_done(input int phase);
		int s;
		bit done;
		done = 1'b1;
		for (s = 0; s < num_slots; s++) begin
			if (phase == 1 && !(seen_st[s][EG_SUSTAIN] && seen_pr[s]))
				done = 1'b0;
			if (phase == 2 && m_op[s].op_type && m_op[s].egtyp && m_env[s] < 124)
				done = 1'b0;
			if (phase == 3 && s == 2 && !seen_st[s][EG_ATTACK])
				done = 1'b0;
			if (phase == 3 && s != 2 && !(seen_st[s][EG_DECAY] && seen_pr[s]))
				done = 1'b0;
		end
		return done;
	endfunction

	task automatic wait_phase(input int phase, input string name);
		int cycles;
		cycles = 0;
		while (!phase_done(phase)) begin
			tick();
			cycles++;
			if (cycles >= wait_limit) begin
				$display("Timeout: the %s phase did not finish in %0d cycles", name, wait_limit);
				$display("Finished with errors");
				$fatal(1, "simulation hung");
			end
		end
	endtask

	initial begin
		int s;
		int i;
		int pick;
		op_word_t op;
		ch_word_t ch;
		seed = 32'h2dcd;
		error_count = 0;
		reset = 1'b1;
		op_wr = 1'b0;
		ch_wr = 1'b0;
		wr_slot = '0;
		op_data = '0;
		ch_data = '0;
		pend_op = 1'b0;
		pend_ch = 1'b0;
		pend_slot = 0;
		model_reset();
		repeat (4) begin
			@(posedge clk);
			#2;
			check_value("env_valid", env_valid, 0);
			check_value("phase_reset", phase_reset, 0);
		end
		reset = 1'b0;
		model_visit(); // slot 0 is visited in the first cycle out of reset.
		tick();
		check_value("env_slot", env_slot, 0);
		check_value("env_level", env_level, 32'h7f);
		check_value("env_state", env_state, EG_DAMP);

		// Key on every slot with rates fast enough to finish the envelope.
		clear_seen();
		for (s = 0; s < num_slots; s++) begin
			op = rand_op(9, 14);
			op.egtyp = s[1];
			op.op_type = s[0]; // odd slots are carriers.
			drive_op(s, op);
			if (s % 2 == 0)
				ch = rand_ch(1'b1);
			ch.sust_on = s[2];
			drive_ch(s, ch);
		end
		wait_phase(1, "attack and decay");

		clear_seen();
		for (s = 0; s < num_slots; s++) begin
			ch = m_ch[s];
			ch.key_on = 1'b0;
			drive_ch(s, ch);
		end
		wait_phase(2, "release");

		// Retrigger all slots; slot 0 gets the fastest attack, slot 2 none.
		clear_seen();
		for (s = 0; s < num_slots; s++) begin
			op = m_op[s];
			op.ar = (s == 0) ? 4'd15 : (s == 2) ? 4'd0 : rate4_t'(rand_range(9, 14));
			drive_op(s, op);
			ch = m_ch[s];
			ch.key_on = 1'b1;
			drive_ch(s, ch);
		end
		wait_phase(3, "retrigger");

		for (i = 0; i < random_sweeps * num_slots; i++) begin
			pick = rand_range(0, 7);
			if (pick == 0)
				drive_op(rand_range(0, num_slots - 1), rand_op(0, 15));
			else if (pick == 1)
				drive_ch(rand_range(0, num_slots - 1), rand_ch(1'(rand_range(0, 1))));
			else
				tick();
		end

		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/eg_top.sv
// Envelope generator top level.
// Connects settings bank, sequencer, state memory and calculator, and
// registers each slot's result.
`timescale 1ns/100ps
`default_nettype none

module eg_top #(
	parameter int num_slots = 18
) (
	input logic clk,
	input logic reset,
	input logic op_wr,
	input logic ch_wr,
	input logic [$clog2(num_slots)-1:0] wr_slot,
	input eg_pkg::op_word_t op_data,
	input eg_pkg::ch_word_t ch_data,
	output logic env_valid,
	output logic [$clog2(num_slots)-1:0] env_slot,
	output eg_pkg::env_t env_level,
	output eg_pkg::eg_state_t env_state,
	output logic phase_reset
);

	import eg_pkg::*;

	localparam int slot_w = $clog2(num_slots);

	logic [slot_w-1:0] slot;
	eg_count_t counter;
	env_t env_prev;
	env_t env_next;
	eg_state_t state_prev;
	eg_state_t state_next;
	logic key_trig;
	logic calc_phase_reset;

	eg_slot_if slot_bus ();

	eg_slot_regs #(.num_slots(num_slots)) eg_slot_regs_inst (
		.clk(clk),
		.reset(reset),
		.op_wr(op_wr),
		.ch_wr(ch_wr),
		.wr_slot(wr_slot),
		.op_data(op_data),
		.ch_data(ch_data),
		.slot(slot),
		.slot_bus(slot_bus.regs)
	);

	eg_timer #(.num_slots(num_slots)) eg_timer_inst (
		.clk(clk),
		.reset(reset),
		.slot(slot),
		.counter(counter)
	);

	eg_state_mem #(.num_slots(num_slots)) eg_state_mem_inst (
		.clk(clk),
		.reset(reset),
		.slot(slot),
		.key_on(slot_bus.ch.key_on),
		.env_next(env_next),
		.state_next(state_next),
		.env_prev(env_prev),
		.state_prev(state_prev),
		.key_trig(key_trig)
	);

	eg_calc_env eg_calc_env_inst (
		.slot_bus(slot_bus.calc),
		.env_prev(env_prev),
		.state_prev(state_prev),
		.counter(counter),
		.key_trig(key_trig),
		.env_next(env_next),
		.state_next(state_next),
		.phase_reset(calc_phase_reset)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			env_valid <= 1'b0;
			phase_reset <= 1'b0;
		end else begin
			env_valid <= 1'b1; // a slot is visited every cycle.
			phase_reset <= calc_phase_reset;
		end
	end

	always_ff @(posedge clk) begin
		env_slot <= slot;
		env_level <= env_next;
		env_state <= state_next;
	end

endmodule

`default_nettype wire

//--- design/eg_calc_env.sv
// Envelope calculator.
// Works out the next state, the key-scaled rate and the next level of one
// slot from its stored envelope and the global counter.
`timescale 1ns/100ps
`default_nettype none

module eg_calc_env (
	eg_slot_if.calc slot_bus,
	input eg_pkg::env_t env_prev,
	input eg_pkg::eg_state_t state_prev,
	input eg_pkg::eg_count_t counter,
	input logic key_trig,
	output eg_pkg::env_t env_next,
	output eg_pkg::eg_state_t state_next,
	output logic phase_reset
);

	import eg_pkg::*;

	op_word_t op;
	ch_word_t ch;
	rate4_t basic_rate;
	logic attack;
	logic [3:0] bf;
	logic [3:0] rks;
	logic [6:0] rate_pre;
	logic [5:0] rate;
	logic [3:0] rate_hi;
	logic [3:0] shift;
	logic [15:0] counter_shifted;
	logic [12:0] mask;
	logic evt;
	logic evt_attack;
	logic [2:0] column;
	logic step;
	logic [7:0] env_inc;
	logic [7:0] env_inc_plus1;
	logic [7:0] env_plus2;

	function automatic env_t sat_level(input logic [7:0] sum);
		return sum[7] ? 7'h7f : sum[6:0];
	endfunction

	assign op = slot_bus.op;
	assign ch = slot_bus.ch;

	always_comb begin
		state_next = state_prev;
		phase_reset = 1'b0;
		if (key_trig) begin
			state_next = EG_DAMP; // retrigger damps the old note first.
		end else if (state_prev == EG_DAMP && env_prev[6:2] == 5'h1f && ch.key_on) begin
			state_next = EG_ATTACK;
			phase_reset = 1'b1; // the oscillator restarts with the attack.
		end else if (state_prev == EG_ATTACK && env_prev == 7'd0) begin
			state_next = EG_DECAY;
		end else if (state_prev == EG_DECAY && env_prev[6:3] == op.sl) begin
			state_next = EG_SUSTAIN;
		end
	end

	always_comb begin
		attack = 1'b0;
		if (!ch.key_on && op.op_type) begin
			basic_rate = op.egtyp ? op.rr : (ch.sust_on ? 4'd5 : 4'd7); // release.
		end else begin
			case (state_next)
				EG_DAMP: begin
					basic_rate = 4'd12;
				end
				EG_ATTACK: begin
					basic_rate = op.ar;
					attack = 1'b1;
				end
				EG_DECAY: begin
					basic_rate = op.dr;
				end
				default: begin
					basic_rate = op.egtyp ? 4'd0 : op.rr;
				end
			endcase
		end
	end

	// Key scaling uses the block and the top bit of fnum.
	assign bf = {ch.block, ch.fnum[8]};
	assign rks = op.ksr ? bf : {2'b00, bf[3:2]};
	assign rate_pre = (basic_rate != 4'd0) ? {1'b0, basic_rate, 2'b00} + {3'b000, rks} : 7'd0;
	assign rate = rate_pre[6] ? 6'h3f : rate_pre[5:0];
	assign rate_hi = rate[5:2];

	// slower rates look at higher counter bits.
	assign shift = 4'd13 - rate_hi;
	assign counter_shifted = counter >> shift;
	assign mask = (13'd1 << shift) - 13'd1;
	assign evt = (counter[12:0] & mask) == 13'd0;
	assign evt_attack = (counter[12:0] & mask & 13'h1ffc) == 13'd0;

	always_comb begin
		column = 3'd0;
		if (attack) begin
			case (rate_hi)
				4'd0, 4'd15: column = 3'd0;
				4'd12, 4'd13, 4'd14: column = {counter[3:2], 1'b0};
				default: column = counter_shifted[2:0];
			endcase
		end else begin
			case (rate_hi)
				4'd0, 4'd15: column = 3'd0;
				4'd13: column = {counter[3:2], counter[0]};
				4'd14: column = {counter[3:2], 1'b0};
				default: column = evt ? counter_shifted[2:0] : 3'd0;
			endcase
		end
	end

	assign step = eg_step_bit({rate[1:0], column});

	assign env_inc = {1'b0, env_prev} + {7'd0, step};
	assign env_inc_plus1 = env_inc + 8'd1;
	assign env_plus2 = {1'b0, env_prev} + 8'd2;

	always_comb begin
		env_next = env_prev;
		if (attack) begin
			case (rate_hi)
				4'd0: env_next = env_prev; // zero rate never moves.
				4'd15: env_next = 7'd0; // full attack in one visit.
				4'd12: env_next = env_prev - (step ? env_prev >> 3 : env_prev >> 4) - 7'd1;
				4'd13: env_next = env_prev - (step ? env_prev >> 2 : env_prev >> 3) - 7'd1;
				4'd14: env_next = env_prev - (step ? env_prev >> 1 : env_prev >> 2) - 7'd1;
				default: begin
					if (evt_attack && step) begin
						env_next = env_prev - (env_prev >> 4) - 7'd1;
					end
				end
			endcase
		end else begin
			case (rate_hi)
				4'd0: env_next = env_prev;
				4'd13: env_next = sat_level(env_inc);
				4'd14: env_next = sat_level(env_inc_plus1);
				4'd15: env_next = sat_level(env_plus2);
				default: begin
					if (evt) begin
						env_next = sat_level(env_inc);
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/eg_state_mem.sv
// Envelope state memory.
// Keeps level, state and last key of every slot and flags key-on edges.
`timescale 1ns/100ps
`default_nettype none

module eg_state_mem #(
	parameter int num_slots = 18
) (
	input logic clk,
	input logic reset,
	input logic [$clog2(num_slots)-1:0] slot,
	input logic key_on,
	input eg_pkg::env_t env_next,
	input eg_pkg::eg_state_t state_next,
	output eg_pkg::env_t env_prev,
	output eg_pkg::eg_state_t state_prev,
	output logic key_trig
);

	import eg_pkg::*;

	env_t env_mem [num_slots];
	eg_state_t state_mem [num_slots];
	logic key_mem [num_slots];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < num_slots; i++) begin
				env_mem[i] <= 7'h7f; // every slot starts silent.
				state_mem[i] <= EG_DAMP;
				key_mem[i] <= 1'b0;
			end
		end else begin
			env_mem[slot] <= env_next;
			state_mem[slot] <= state_next;
			key_mem[slot] <= key_on;
		end
	end

	assign env_prev = env_mem[slot];
	assign state_prev = state_mem[slot];

	// A key that was off on the previous visit and is on now.
	assign key_trig = key_on & ~key_mem[slot];

endmodule

`default_nettype wire

//--- design/eg_timer.sv
// Slot sequencer and global envelope counter.
`timescale 1ns/100ps
`default_nettype none

module eg_timer #(
	parameter int num_slots = 18
) (
	input logic clk,
	input logic reset,
	output logic [$clog2(num_slots)-1:0] slot,
	output eg_pkg::eg_count_t counter
);

	localparam int slot_w = $clog2(num_slots);

	always_ff @(posedge clk) begin
		if (reset) begin
			slot <= '0;
			counter <= '0;
		end else if (slot == slot_w'(num_slots - 1)) begin
			slot <= '0;
			counter <= counter + 1'b1; // one tick per full sweep.
		end else begin
			slot <= slot + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/eg_slot_regs.sv
// Slot settings bank.
// Holds the host-written operator and channel words of every slot and
// presents the words of the visited slot.
`timescale 1ns/100ps
`default_nettype none

module eg_slot_regs #(
	parameter int num_slots = 18
) (
	input logic clk,
	input logic reset,
	input logic op_wr,
	input logic ch_wr,
	input logic [$clog2(num_slots)-1:0] wr_slot,
	input eg_pkg::op_word_t op_data,
	input eg_pkg::ch_word_t ch_data,
	input logic [$clog2(num_slots)-1:0] slot,
	eg_slot_if.regs slot_bus
);

	import eg_pkg::*;

	op_word_t op_mem [num_slots];
	ch_word_t ch_mem [num_slots];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < num_slots; i++) begin
				op_mem[i] <= '0;
				ch_mem[i] <= '0;
			end
		end else begin
			if (op_wr && wr_slot < num_slots) begin
				op_mem[wr_slot] <= op_data; // seen on the next visit to that slot.
			end
			if (ch_wr && wr_slot < num_slots) begin
				ch_mem[wr_slot] <= ch_data;
			end
		end
	end

	// the calculator sees the stored words in the same cycle.
	assign slot_bus.op = op_mem[slot];
	assign slot_bus.ch = ch_mem[slot];

endmodule

`default_nettype wire

//--- design/eg_slot_if.sv
// Slot settings bus.
// Carries the operator and channel words of the visited slot to the calculator.
`timescale 1ns/100ps
`default_nettype none

interface eg_slot_if;

	import eg_pkg::*;

	op_word_t op; // operator settings of the visited slot.
	ch_word_t ch; // channel settings of the visited slot.

	modport regs (
		output op,
		output ch
	);

	modport calc (
		input op,
		input ch
	);

endinterface

`default_nettype wire

//--- design/eg_pkg.sv
// Envelope generator package.
// Widths, state encoding, settings word layouts and the rate step table.
`default_nettype none

package eg_pkg;

	typedef logic [6:0] env_t; // attenuation, 127 is silent.
	typedef logic [3:0] rate4_t;
	typedef logic [8:0] fnum_t;
	typedef logic [2:0] block_t;
	typedef logic [15:0] eg_count_t;

	typedef enum logic [1:0] {
		EG_DAMP = 2'b00,
		EG_ATTACK = 2'b01,
		EG_DECAY = 2'b10,
		EG_SUSTAIN = 2'b11
	} eg_state_t;

	typedef struct packed {
		logic egtyp; // set for sustained tones.
		logic ksr;
		rate4_t ar;
		rate4_t dr;
		rate4_t sl;
		rate4_t rr;
		logic op_type; // 1 marks a carrier.
	} op_word_t;

	typedef struct packed {
		logic sust_on;
		logic key_on;
		fnum_t fnum;
		block_t block;
	} ch_word_t;

	// index is {row, column}; the row comes from the low rate bits.
	function automatic logic eg_step_bit(input logic [4:0] idx);
		logic [7:0] row_bits;
		case (idx[4:3])
			2'd0: row_bits = 8'b1010_1010;
			2'd1: row_bits = 8'b1011_1010;
			2'd2: row_bits = 8'b1110_1110;
			default: row_bits = 8'b1111_1110;
		endcase
		return row_bits[idx[2:0]];
	endfunction

endpackage

`default_nettype wire
